// File: cmp_rs_cfg.svh
`ifndef CMP_RS_CFG_SVH
`define CMP_RS_CFG_SVH

// number of station entries
`define CMP_RS_SIZE 4

// operand, pc and target width
`define XLEN 32

// reorder-buffer index width
// tag 0 is reserved for "no producer"
`define ROB_TAG_W 4

`endif

// File: cmp_rs_pkg.sv
package cmp_rs_pkg;

`include "cmp_rs_cfg.svh"

    // operand, pc or target word
    typedef logic [`XLEN-1:0] word_t;

    // reorder-buffer index
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // compare ops, encoded as the RV32I funct3 field
    // slt and sltu write a register, the rest are branches
    typedef enum logic [2:0] {
        op_beq  = 3'b000,
        op_bne  = 3'b001,
        op_slt  = 3'b010,
        op_sltu = 3'b011,
        op_blt  = 3'b100,
        op_bge  = 3'b101,
        op_bltu = 3'b110,
        op_bgeu = 3'b111
    } cmpop_t;

    // one bit per entry
    typedef logic [`CMP_RS_SIZE-1:0] entry_sel_t;

endpackage

// File: cmp_rs_dispatch.sv
`timescale 1ns/100ps

module cmp_rs_dispatch import cmp_rs_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       flush_i,
    input  logic       disp_req_i,
    input  entry_sel_t busy_i,
    output logic       disp_ack_o,
    output entry_sel_t load_o,
    output logic       full_o
);

    typedef enum logic {
        st_idle,
        st_acked
    } hs_state_t;

    hs_state_t  state_q;
    entry_sel_t free_sel;
    logic       load_go;

    // lowest clear bit of busy_i, zero when all entries are taken
    assign free_sel = ~busy_i & (busy_i + 1'b1);

    // one load per handshake, only while waiting for ack
    assign load_go = disp_req_i && (state_q == st_idle) && (free_sel != '0) && !flush_i;

    assign load_o     = load_go ? free_sel : '0;
    assign disp_ack_o = (state_q == st_acked);

    // four-phase handshake
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    // ack rises the edge after the load
                    if (load_go) begin
                        state_q <= st_acked;
                    end
                end
                st_acked: begin
                    if (!disp_req_i) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // full flag includes the entry being loaded this cycle
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            full_o <= 1'b0;
        end else begin
            full_o <= &(busy_i | load_o);
        end
    end

endmodule

// File: cmp_rs_entry.sv
`timescale 1ns/100ps

module cmp_rs_entry import cmp_rs_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  logic     load_i,
    input  cmpop_t   op_i,
    input  word_t    pc_i,
    input  word_t    imm_i,
    input  rob_tag_t rob_tag_i,
    input  logic     rs1_ready_i,
    input  word_t    rs1_val_i,
    input  rob_tag_t rs1_tag_i,
    input  logic     rs2_ready_i,
    input  word_t    rs2_val_i,
    input  rob_tag_t rs2_tag_i,
    input  logic     cdb_valid_i,
    input  rob_tag_t cdb_tag_i,
    input  word_t    cdb_value_i,
    input  logic     grant_i,
    output logic     busy_o,
    output logic     done_req_o,
    output rob_tag_t res_tag_o,
    output logic     res_value_o,
    output word_t    res_target_o,
    output logic     res_is_br_o
);

    // control state
    logic busy_q;
    logic rs1_rdy_q;
    logic rs2_rdy_q;
    logic done_q;

    // held instruction
    cmpop_t   op_q;
    word_t    pc_q;
    word_t    imm_q;
    rob_tag_t rob_tag_q;
    rob_tag_t rs1_tag_q;
    rob_tag_t rs2_tag_q;
    word_t    rs1_val_q;
    word_t    rs2_val_q;

    // evaluated result
    logic  res_bit_q;
    word_t res_target_q;

    logic  rs1_hit_new;
    logic  rs2_hit_new;
    logic  rs1_hit;
    logic  rs2_hit;
    logic  eval_go;
    logic  cmp_bit;
    logic  is_br;
    word_t target;

    // snoop on the incoming payload during the load cycle
    assign rs1_hit_new = cdb_valid_i && !rs1_ready_i && (rs1_tag_i == cdb_tag_i);
    assign rs2_hit_new = cdb_valid_i && !rs2_ready_i && (rs2_tag_i == cdb_tag_i);

    // snoop on the stored tags afterwards
    assign rs1_hit = cdb_valid_i && busy_q && !rs1_rdy_q && (rs1_tag_q == cdb_tag_i);
    assign rs2_hit = cdb_valid_i && busy_q && !rs2_rdy_q && (rs2_tag_q == cdb_tag_i);

    assign eval_go = busy_q && rs1_rdy_q && rs2_rdy_q && !done_q;

    always_comb begin
        case (op_q)
            op_beq:          cmp_bit = (rs1_val_q == rs2_val_q);
            op_bne:          cmp_bit = (rs1_val_q != rs2_val_q);
            op_blt, op_slt:  cmp_bit = ($signed(rs1_val_q) < $signed(rs2_val_q));
            op_bge:          cmp_bit = ($signed(rs1_val_q) >= $signed(rs2_val_q));
            op_bltu, op_sltu: cmp_bit = (rs1_val_q < rs2_val_q);
            op_bgeu:         cmp_bit = (rs1_val_q >= rs2_val_q);
            default:         cmp_bit = 1'b0;
        endcase
    end

    assign is_br  = !((op_q == op_slt) || (op_q == op_sltu));
    // slt and sltu carry no target
    assign target = !is_br ? '0 : (cmp_bit ? pc_q + imm_q : pc_q + word_t'(4));

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q    <= 1'b0;
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
            done_q    <= 1'b0;
        end else if (load_i) begin
            busy_q    <= 1'b1;
            rs1_rdy_q <= rs1_ready_i || rs1_hit_new;
            rs2_rdy_q <= rs2_ready_i || rs2_hit_new;
            done_q    <= 1'b0;
        end else if (grant_i) begin
            // result leaves on this edge, entry is free again
            busy_q    <= 1'b0;
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            if (rs1_hit) begin
                rs1_rdy_q <= 1'b1;
            end
            if (rs2_hit) begin
                rs2_rdy_q <= 1'b1;
            end
            if (eval_go) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            op_q      <= op_i;
            pc_q      <= pc_i;
            imm_q     <= imm_i;
            rob_tag_q <= rob_tag_i;
            rs1_tag_q <= rs1_tag_i;
            rs2_tag_q <= rs2_tag_i;
            rs1_val_q <= rs1_ready_i ? rs1_val_i : cdb_value_i;
            rs2_val_q <= rs2_ready_i ? rs2_val_i : cdb_value_i;
        end else begin
            if (rs1_hit) begin
                rs1_val_q <= cdb_value_i;
            end
            if (rs2_hit) begin
                rs2_val_q <= cdb_value_i;
            end
        end
        if (eval_go) begin
            res_bit_q    <= cmp_bit;
            res_target_q <= target;
        end
    end

    assign busy_o       = busy_q;
    assign done_req_o   = done_q;
    assign res_tag_o    = rob_tag_q;
    assign res_value_o  = res_bit_q;
    assign res_target_o = res_target_q;
    assign res_is_br_o  = is_br;

endmodule

// File: cmp_rs_cdb_arb.sv
`timescale 1ns/100ps
`include "cmp_rs_cfg.svh"

module cmp_rs_cdb_arb import cmp_rs_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  entry_sel_t              req_i,
    input  rob_tag_t                res_tag_i [`CMP_RS_SIZE],
    input  logic [`CMP_RS_SIZE-1:0] res_value_i,
    input  word_t                   res_target_i [`CMP_RS_SIZE],
    input  logic [`CMP_RS_SIZE-1:0] res_is_br_i,
    output entry_sel_t              grant_o,
    output logic                    cdb_cmp_valid_o,
    output rob_tag_t                cdb_cmp_tag_o,
    output word_t                   cdb_cmp_value_o,
    output word_t                   cdb_cmp_target_o,
    output logic                    cdb_cmp_is_br_o
);

    localparam int N     = `CMP_RS_SIZE;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] gnt_idx;
    logic             gnt_any;

    // first requester at or after the pointer
    always_comb begin
        int unsigned cand;
        grant_o = '0;
        gnt_idx = '0;
        gnt_any = 1'b0;
        for (int k = 0; k < N; k++) begin
            cand = (int'(ptr_q) + k) % N;
            if (!gnt_any && req_i[cand]) begin
                gnt_any        = 1'b1;
                gnt_idx        = IDX_W'(cand);
                grant_o[cand]  = 1'b1;
            end
        end
    end

    // pointer moves past the winner
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ptr_q <= '0;
        end else if (gnt_any) begin
            ptr_q <= (gnt_idx == IDX_W'(N - 1)) ? '0 : gnt_idx + 1'b1;
        end
    end

    // a flushed winner is never broadcast
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            cdb_cmp_valid_o <= 1'b0;
        end else begin
            cdb_cmp_valid_o <= gnt_any;
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_any) begin
            cdb_cmp_tag_o    <= res_tag_i[gnt_idx];
            cdb_cmp_value_o  <= word_t'(res_value_i[gnt_idx]);
            cdb_cmp_target_o <= res_target_i[gnt_idx];
            cdb_cmp_is_br_o  <= res_is_br_i[gnt_idx];
        end
    end

endmodule

// File: cmp_rs_top.sv
`timescale 1ns/100ps
`include "cmp_rs_cfg.svh"

module cmp_rs_top import cmp_rs_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    // dispatch from the decoder
    input  logic     disp_req_i,
    input  cmpop_t   disp_op_i,
    input  word_t    disp_pc_i,
    input  word_t    disp_imm_i,
    input  rob_tag_t disp_rob_tag_i,
    input  logic     disp_rs1_ready_i,
    input  word_t    disp_rs1_val_i,
    input  rob_tag_t disp_rs1_tag_i,
    input  logic     disp_rs2_ready_i,
    input  word_t    disp_rs2_val_i,
    input  rob_tag_t disp_rs2_tag_i,
    output logic     disp_ack_o,
    output logic     full_o,
    // external CDB snoop
    input  logic     cdb_valid_i,
    input  rob_tag_t cdb_tag_i,
    input  word_t    cdb_value_i,
    // compare broadcast
    output logic     cdb_cmp_valid_o,
    output rob_tag_t cdb_cmp_tag_o,
    output word_t    cdb_cmp_value_o,
    output word_t    cdb_cmp_target_o,
    output logic     cdb_cmp_is_br_o
);

    entry_sel_t              busy;
    entry_sel_t              load;
    entry_sel_t              done_req;
    entry_sel_t              grant;
    logic [`CMP_RS_SIZE-1:0] res_value;
    logic [`CMP_RS_SIZE-1:0] res_is_br;
    rob_tag_t                res_tag [`CMP_RS_SIZE];
    word_t                   res_target [`CMP_RS_SIZE];

    cmp_rs_dispatch u_dispatch (
        .clk        (clk),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .disp_req_i (disp_req_i),
        .busy_i     (busy),
        .disp_ack_o (disp_ack_o),
        .load_o     (load),
        .full_o     (full_o)
    );

    // every entry sees the same payload, load picks one
    for (genvar i = 0; i < `CMP_RS_SIZE; i++) begin : g_entry
        cmp_rs_entry u_entry (
            .clk          (clk),
            .reset_i      (reset_i),
            .flush_i      (flush_i),
            .load_i       (load[i]),
            .op_i         (disp_op_i),
            .pc_i         (disp_pc_i),
            .imm_i        (disp_imm_i),
            .rob_tag_i    (disp_rob_tag_i),
            .rs1_ready_i  (disp_rs1_ready_i),
            .rs1_val_i    (disp_rs1_val_i),
            .rs1_tag_i    (disp_rs1_tag_i),
            .rs2_ready_i  (disp_rs2_ready_i),
            .rs2_val_i    (disp_rs2_val_i),
            .rs2_tag_i    (disp_rs2_tag_i),
            .cdb_valid_i  (cdb_valid_i),
            .cdb_tag_i    (cdb_tag_i),
            .cdb_value_i  (cdb_value_i),
            .grant_i      (grant[i]),
            .busy_o       (busy[i]),
            .done_req_o   (done_req[i]),
            .res_tag_o    (res_tag[i]),
            .res_value_o  (res_value[i]),
            .res_target_o (res_target[i]),
            .res_is_br_o  (res_is_br[i])
        );
    end

    cmp_rs_cdb_arb u_cdb_arb (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .req_i            (done_req),
        .res_tag_i        (res_tag),
        .res_value_i      (res_value),
        .res_target_i     (res_target),
        .res_is_br_i      (res_is_br),
        .grant_o          (grant),
        .cdb_cmp_valid_o  (cdb_cmp_valid_o),
        .cdb_cmp_tag_o    (cdb_cmp_tag_o),
        .cdb_cmp_value_o  (cdb_cmp_value_o),
        .cdb_cmp_target_o (cdb_cmp_target_o),
        .cdb_cmp_is_br_o  (cdb_cmp_is_br_o)
    );

endmodule

// File: cmp_rs_props.sv
`timescale 1ns/100ps

module cmp_rs_props import cmp_rs_pkg::*; (
    input logic       clk,
    input logic       reset_i,
    input logic       disp_req_i,
    input logic       disp_ack_i,
    input logic       full_i,
    input logic       bcast_valid_i,
    input rob_tag_t   bcast_tag_i,
    input entry_sel_t grant_i
);

    int fail_cnt = 0;

    // ack answers a request that was high on the load edge
    ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(disp_ack_i) |-> $past(disp_req_i))
        else begin
            fail_cnt++;
            $error("disp_ack_o rose without a pending request");
        end

    // tag 0 means no producer
    tag_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        bcast_valid_i |-> (bcast_tag_i != '0))
        else begin
            fail_cnt++;
            $error("broadcast carries tag 0");
        end

    grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(grant_i))
        else begin
            fail_cnt++;
            $error("arbiter granted more than one entry");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |-> (!full_i && !disp_ack_i))
        else begin
            fail_cnt++;
            $error("full_o or disp_ack_o high right after reset");
        end

endmodule

bind cmp_rs_top cmp_rs_props props0 (
    .clk           (clk),
    .reset_i       (reset_i),
    .disp_req_i    (disp_req_i),
    .disp_ack_i    (disp_ack_o),
    .full_i        (full_o),
    .bcast_valid_i (cdb_cmp_valid_o),
    .bcast_tag_i   (cdb_cmp_tag_o),
    .grant_i       (grant)
);

// File: cmp_rs_tb.sv
`timescale 1ns/100ps
`include "cmp_rs_cfg.svh"

module cmp_rs_tb import cmp_rs_pkg::*; ();

    localparam int NTAGS       = 1 << `ROB_TAG_W;
    // directed groups plus the random ready group
    localparam int NUM_DISP    = 24 + 3 + 2 + (`CMP_RS_SIZE + 1) + 5 + `CMP_RS_SIZE;
    localparam int CYCLE_LIMIT = 40 * NUM_DISP + 200;
    localparam word_t SIGN_BIT = word_t'(1) << (`XLEN - 1);

    // scoreboard state per rob tag
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_PEND    = 2'd1;
    localparam logic [1:0] ST_DONE    = 2'd2;
    localparam logic [1:0] ST_FLUSHED = 2'd3;

    logic     clk;
    logic     reset_i;
    logic     flush_i;
    logic     disp_req_i;
    cmpop_t   disp_op_i;
    word_t    disp_pc_i;
    word_t    disp_imm_i;
    rob_tag_t disp_rob_tag_i;
    logic     disp_rs1_ready_i;
    word_t    disp_rs1_val_i;
    rob_tag_t disp_rs1_tag_i;
    logic     disp_rs2_ready_i;
    word_t    disp_rs2_val_i;
    rob_tag_t disp_rs2_tag_i;
    logic     disp_ack_o;
    logic     full_o;
    logic     cdb_valid_i;
    rob_tag_t cdb_tag_i;
    word_t    cdb_value_i;
    logic     cdb_cmp_valid_o;
    rob_tag_t cdb_cmp_tag_o;
    word_t    cdb_cmp_value_o;
    word_t    cdb_cmp_target_o;
    logic     cdb_cmp_is_br_o;

    integer   seed = 933;
    int       mismatch_cnt = 0;
    int       other_cnt = 0;
    int       cycle_cnt = 0;
    rob_tag_t next_tag = 1;

    logic [1:0] sb_state [NTAGS];
    word_t      sb_value [NTAGS];
    word_t      sb_target [NTAGS];
    logic       sb_is_br [NTAGS];

    cmp_rs_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected result straight from the compare and target rules
    function automatic void cmp_ref(input cmpop_t op, input word_t a, input word_t b,
                                    input word_t pc, input word_t imm, output logic taken,
                                    output word_t target, output logic is_br);
        logic u_lt;
        logic s_lt;
        u_lt = (a < b);
        // flipping the sign bit turns a signed compare into an unsigned one
        s_lt = ((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
        case (op)
            op_beq:           taken = (a == b);
            op_bne:           taken = (a != b);
            op_blt, op_slt:   taken = s_lt;
            op_bge:           taken = !s_lt;
            op_bltu, op_sltu: taken = u_lt;
            default:          taken = !u_lt;
        endcase
        is_br = (op != op_slt) && (op != op_sltu);
        if (!is_br) begin
            target = '0;
        end else begin
            target = taken ? pc + imm : pc + word_t'(4);
        end
    endfunction

    function automatic rob_tag_t next_rob_tag();
        rob_tag_t t;
        t = next_tag;
        next_tag = (next_tag == rob_tag_t'(NTAGS - 1)) ? rob_tag_t'(1) : next_tag + 1'b1;
        return t;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int k = 0; k < NTAGS; k++) begin
            if (sb_state[k] == ST_PEND) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // operand tag 0 means the value is ready, otherwise a or b comes from the CDB
    task automatic dispatch(input cmpop_t op, input word_t a, input word_t b,
                            input rob_tag_t t1, input rob_tag_t t2,
                            input logic snoop, input rob_tag_t tag);
        logic  taken;
        logic  is_br;
        word_t pc;
        word_t imm;
        word_t target;
        pc  = word_t'($random(seed)) & ~word_t'(3);
        imm = word_t'($random(seed)) & ~word_t'(1);
        while (sb_state[tag] == ST_PEND) @(negedge clk);
        cmp_ref(op, a, b, pc, imm, taken, target, is_br);
        sb_value[tag]  = word_t'(taken);
        sb_target[tag] = target;
        sb_is_br[tag]  = is_br;
        sb_state[tag]  = ST_PEND;
        @(negedge clk);
        disp_req_i       = 1'b1;
        disp_op_i        = op;
        disp_pc_i        = pc;
        disp_imm_i       = imm;
        disp_rob_tag_i   = tag;
        disp_rs1_ready_i = (t1 == 0);
        disp_rs1_val_i   = (t1 == 0) ? a : word_t'($random(seed));
        disp_rs1_tag_i   = t1;
        disp_rs2_ready_i = (t2 == 0);
        disp_rs2_val_i   = (t2 == 0) ? b : word_t'($random(seed));
        disp_rs2_tag_i   = t2;
        // CDB hit in the load cycle itself
        if (snoop) begin
            cdb_valid_i = 1'b1;
            cdb_tag_i   = (t1 != 0) ? t1 : t2;
            cdb_value_i = (t1 != 0) ? a : b;
        end
        @(negedge clk);
        if (snoop) begin
            cdb_valid_i = 1'b0;
        end
        while (!disp_ack_o) @(negedge clk);
        disp_req_i = 1'b0;
        while (disp_ack_o) @(negedge clk);
    endtask

    task automatic cdb_send(input rob_tag_t tag, input word_t value);
        @(negedge clk);
        cdb_valid_i = 1'b1;
        cdb_tag_i   = tag;
        cdb_value_i = value;
        @(negedge clk);
        cdb_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (pending_count() != 0) @(negedge clk);
    endtask

    task automatic expect_broadcast(input rob_tag_t tag);
        @(negedge clk);
        while (cdb_cmp_valid_o !== 1'b1) @(negedge clk);
        check_tag("cdb_cmp_tag_o", cdb_cmp_tag_o, tag);
    endtask

    task automatic report_missing();
        for (int k = 0; k < NTAGS; k++) begin
            if (sb_state[k] == ST_PEND) begin
                other_cnt++;
                $display("result for tag %0d was never broadcast", k);
            end
        end
    endtask

    task automatic finish_run();
        int total;
        total = mismatch_cnt + other_cnt + dut0.props0.fail_cnt;
        $display("error counts: %0d mismatch, %0d other, %0d assertion",
                 mismatch_cnt, other_cnt, dut0.props0.fail_cnt);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // scoreboard lookup for every compare broadcast
    always @(negedge clk) begin : compare_proc
        rob_tag_t t;
        t = cdb_cmp_tag_o;
        if (!reset_i && cdb_cmp_valid_o === 1'b1) begin
            if (sb_state[t] == ST_PEND) begin
                check_word("cdb_cmp_value_o", cdb_cmp_value_o, sb_value[t]);
                check_word("cdb_cmp_target_o", cdb_cmp_target_o, sb_target[t]);
                check_bit("cdb_cmp_is_br_o", cdb_cmp_is_br_o, sb_is_br[t]);
                sb_state[t] = ST_DONE;
            end else if (sb_state[t] == ST_DONE) begin
                other_cnt++;
                $display("%0t: tag %0d was broadcast twice", $time, t);
            end else if (sb_state[t] == ST_FLUSHED) begin
                other_cnt++;
                $display("%0t: tag %0d was broadcast after a flush", $time, t);
            end else begin
                other_cnt++;
                $display("%0t: unexpected broadcast of tag %0d", $time, t);
            end
        end
    end

    initial begin : run_limit
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_cnt++;
        $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
        report_missing();
        finish_run();
    end

    initial begin : main_seq
        int       i;
        word_t    a;
        word_t    b;
        integer   r;
        rob_tag_t tag_a;
        rob_tag_t held_tag [`CMP_RS_SIZE];
        rob_tag_t flush_tag [3];
        reset_i          = 1'b1;
        flush_i          = 1'b0;
        disp_req_i       = 1'b0;
        disp_op_i        = op_beq;
        disp_pc_i        = '0;
        disp_imm_i       = '0;
        disp_rob_tag_i   = '0;
        disp_rs1_ready_i = 1'b0;
        disp_rs1_val_i   = '0;
        disp_rs1_tag_i   = '0;
        disp_rs2_ready_i = 1'b0;
        disp_rs2_val_i   = '0;
        disp_rs2_tag_i   = '0;
        cdb_valid_i      = 1'b0;
        cdb_tag_i        = '0;
        cdb_value_i      = '0;
        for (i = 0; i < NTAGS; i++) begin
            sb_state[i] = ST_IDLE;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // random ready operands over every opcode, some with equal operands
        for (i = 0; i < 24; i++) begin
            r = $random(seed);
            a = $random(seed);
            b = (r[1:0] == 2'b00) ? a : word_t'($random(seed));
            dispatch(cmpop_t'(3'(i)), a, b, 0, 0, 1'b0, next_rob_tag());
        end
        wait_idle();

        // tagged operands wait for the CDB
        tag_a = next_rob_tag();
        dispatch(op_blt, 32'hffff_fff9, 32'd3, 11, 0, 1'b0, tag_a);
        dispatch(op_sltu, 32'd5, 32'hffff_0000, 0, 12, 1'b0, next_rob_tag());
        dispatch(op_bgeu, 32'hffff_fff9, 32'hffff_0000, 11, 12, 1'b0, next_rob_tag());
        repeat (6) begin
            @(negedge clk);
            if (cdb_cmp_valid_o) begin
                other_cnt++;
                $display("%0t: broadcast before its operand tags arrived", $time);
            end
        end
        cdb_send(11, 32'hffff_fff9);
        expect_broadcast(tag_a);
        cdb_send(12, 32'hffff_0000);
        wait_idle();

        // CDB match in the dispatch cycle
        dispatch(op_blt, SIGN_BIT, 32'd1, 6, 0, 1'b1, next_rob_tag());
        dispatch(op_beq, 32'h0bad_f00d, 32'h0bad_f00d, 7, 7, 1'b1, next_rob_tag());
        wait_idle();

        // fill every entry, then one more dispatch stalls until a tag arrives
        for (i = 0; i < `CMP_RS_SIZE; i++) begin
            held_tag[i] = next_rob_tag();
            dispatch(op_bge, word_t'(i * 77 - 150), 32'd100, rob_tag_t'(2 + i), 0, 1'b0,
                     held_tag[i]);
        end
        check_bit("full_o", full_o, 1'b1);
        fork
            dispatch(op_bltu, 32'd1, 32'd2, 0, 0, 1'b0, next_rob_tag());
            begin
                repeat (6) begin
                    @(negedge clk);
                    if (disp_ack_o) begin
                        other_cnt++;
                        $display("%0t: disp_ack_o rose while every entry was busy", $time);
                    end
                end
                cdb_send(2, word_t'(-150));
                expect_broadcast(held_tag[0]);
            end
        join
        for (i = 1; i < `CMP_RS_SIZE; i++) begin
            cdb_send(rob_tag_t'(2 + i), word_t'(i * 77 - 150));
        end
        wait_idle();

        // flush waiting entries, their tags must never come out
        for (i = 0; i < 3; i++) begin
            flush_tag[i] = next_rob_tag();
            dispatch(op_bne, 32'd9, 32'd9, 0, rob_tag_t'(13 + i), 1'b0, flush_tag[i]);
        end
        @(negedge clk);
        flush_i = 1'b1;
        for (i = 0; i < 3; i++) begin
            sb_state[flush_tag[i]] = ST_FLUSHED;
        end
        @(negedge clk);
        flush_i = 1'b0;
        for (i = 0; i < 3; i++) begin
            cdb_send(rob_tag_t'(13 + i), 32'd9);
        end
        repeat (8) @(negedge clk);
        dispatch(op_slt, 32'hffff_ff00, 32'd4, 0, 0, 1'b0, next_rob_tag());
        dispatch(op_bne, 32'd4, 32'd5, 0, 0, 1'b0, next_rob_tag());
        wait_idle();

        // one tag wakes every entry at once
        for (i = 0; i < `CMP_RS_SIZE; i++) begin
            a = $random(seed);
            dispatch(cmpop_t'(3'(i + 3)), a, 32'h0000_8000, 0, 10, 1'b0, next_rob_tag());
        end
        cdb_send(10, 32'h0000_8000);
        wait_idle();

        // late duplicates would still show up here
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

// File: files.f
+incdir+.
cmp_rs_pkg.sv
cmp_rs_dispatch.sv
cmp_rs_entry.sv
cmp_rs_cdb_arb.sv
cmp_rs_top.sv
cmp_rs_props.sv
cmp_rs_tb.sv
